/* src/gpuPkg.sv */
`default_nettype none

package gpuPkg;

	// ------------------------------------------------------------------
	// Sizes.
	// ------------------------------------------------------------------
	localparam int fifoDepthLog = 4;                 // Log2 of the command FIFO depth.
	localparam int fifoDepth    = 1 << fifoDepthLog;
	localparam int wordWidth    = 32;                // CPU bus and GP0/GP1 word.
	localparam int coordWidth   = 13;                // Signed screen coordinate after offset.
	localparam int colorWidth   = 9;                 // Colour component in 0..256.

	// GP0 command bytes. The triangle codes leave bits 1:0 free.
	localparam logic [7:0] cmdFlatTri    = 8'h20;
	localparam logic [7:0] cmdGouraudTri = 8'h30;
	localparam logic [7:0] cmdDrawMode   = 8'hE1;
	localparam logic [7:0] cmdDrawOffset = 8'hE5;

	// GP1 opcodes, taken from bits 29:24 of the word.
	localparam logic [5:0] gp1Reset         = 6'd0;
	localparam logic [5:0] gp1CmdReset      = 6'd1;
	localparam logic [5:0] gp1AckIrq        = 6'd2;
	localparam logic [5:0] gp1DisplayEnable = 6'd3;
	localparam logic [5:0] gp1DmaDir        = 6'd4;
	localparam logic [5:0] gp1DisplayArea   = 6'd5;
	localparam logic [5:0] gp1RangeX        = 6'd6;
	localparam logic [5:0] gp1RangeY        = 6'd7;
	localparam logic [5:0] gp1DisplayMode   = 6'd8;

	// ------------------------------------------------------------------
	// Status word bit positions (lowest bit of each field).
	// ------------------------------------------------------------------
	localparam int stTexPageX      = 0;   // 4 bits.
	localparam int stTexPageY      = 4;
	localparam int stTransparency  = 5;   // 2 bits.
	localparam int stTexFormat     = 7;   // 2 bits.
	localparam int stDither        = 9;
	localparam int stDrawToDisplay = 10;
	localparam int stTexDisable    = 15;
	localparam int stHoriz368      = 16;
	localparam int stHorizRes      = 17;  // 2 bits.
	localparam int stVertRes       = 19;
	localparam int stVideoMode     = 20;
	localparam int stRgb888        = 21;
	localparam int stInterlace     = 22;
	localparam int stDispDisabled  = 23;
	localparam int stCmdReady      = 26;
	localparam int stDmaDir        = 29;  // 2 bits.

	// E1 attributes. Field order follows the E1 word, so bits 11:0 map straight in.
	typedef struct packed {
		logic       textureDisable;  // Bit 11.
		logic       drawToDisplay;   // Bit 10.
		logic       dither;          // Bit 9.
		logic [1:0] texFormat;       // Bits 8:7.
		logic [1:0] transparency;    // Bits 6:5.
		logic       texPageY;        // Bit 4.
		logic [3:0] texPageX;        // Bits 3:0.
	} drawModeT;

	// GP1 display mode fields.
	typedef struct packed {
		logic       interlace;
		logic       rgb888;
		logic       videoMode;       // 0 NTSC, 1 PAL.
		logic       vertRes;
		logic [1:0] horizRes;
		logic       horiz368;
		logic       reverseFlag;
	} displayModeT;

	typedef struct packed {
		logic signed [coordWidth-1:0] x;
		logic signed [coordWidth-1:0] y;
		logic        [colorWidth-1:0] r;
		logic        [colorWidth-1:0] g;
		logic        [colorWidth-1:0] b;
	} vertexT;

	typedef struct packed {
		vertexT v0;
		vertexT v1;
		vertexT v2;
		logic   semiTransp;
	} triangleT;

endpackage

`default_nettype wire

/* src/gpuCmdFifo.sv */
`default_nettype none

module gpuCmdFifo (
	input  logic                         clk,
	input  logic                         rstGPU,
	input  logic                         flush,
	input  logic                         wrEn,
	input  logic [gpuPkg::wordWidth-1:0] wrData,
	input  logic                         rdEn,
	output logic [gpuPkg::wordWidth-1:0] rdData,
	output logic                         full,
	output logic                         empty
);
	import gpuPkg::*;

	logic [wordWidth-1:0]  mem [fifoDepth];
	logic [fifoDepthLog:0] wrPtr;   // Extra MSB tells full from empty.
	logic [fifoDepthLog:0] rdPtr;
	logic [fifoDepthLog:0] count;
	logic                  push;
	logic                  pop;

	assign count = wrPtr - rdPtr;
	assign full  = (count == (fifoDepthLog + 1)'(fifoDepth));
	assign empty = (wrPtr == rdPtr);
	assign push  = wrEn & ~full;    // A word sent to a full FIFO is lost.
	assign pop   = rdEn & ~empty;

	always_ff @(posedge clk) begin
		if (rstGPU || flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop)  rdPtr <= rdPtr + 1'b1;
		end
	end

	// Storage and the registered read port.
	always_ff @(posedge clk) begin
		if (push) mem[wrPtr[fifoDepthLog-1:0]] <= wrData;
		if (pop)  rdData <= mem[rdPtr[fifoDepthLog-1:0]]; // Valid the cycle after rdEn.
	end

	// The parser must never pull from an empty FIFO.
	assert property (@(posedge clk) disable iff (rstGPU) rdEn |-> !empty)
		else $error("FIFO read while empty.");
	assert property (@(posedge clk) disable iff (rstGPU) count <= (fifoDepthLog + 1)'(fifoDepth))
		else $error("FIFO count past depth.");

endmodule

`default_nettype wire

/* src/gpuControlRegs.sv */
`default_nettype none

module gpuControlRegs (
	input  logic                         clk,
	input  logic                         rstGPU,
	input  logic                         gp1Write,
	input  logic [gpuPkg::wordWidth-1:0] gp1Data,
	input  gpuPkg::drawModeT             drawMode,
	input  logic                         cmdReady,
	output logic                         gpuReset,
	output logic                         cmdReset,
	output logic [gpuPkg::wordWidth-1:0] status
);
	import gpuPkg::*;

	logic [5:0]  opcode;
	logic        regReset;
	logic        displayDisabled;
	logic [1:0]  dmaDir;
	displayModeT displayMode;

	assign opcode   = gp1Data[29:24];
	assign gpuReset = gp1Write && (opcode == gp1Reset);    // Single-cycle strobe that acts as rstGPU.
	assign cmdReset = gp1Write && (opcode == gp1CmdReset); // Flushes FIFO and parser.
	assign regReset = rstGPU | gpuReset;

	// ------------------------------------------------------------------
	// GP1 register writes.
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (regReset) begin
			displayDisabled <= 1'b1;             // Display starts off.
			dmaDir          <= 2'd0;
			displayMode     <= '0;
		end else if (gp1Write) begin
			case (opcode)
				gp1AckIrq:        ;                // No IRQ logic here.
				gp1DisplayEnable: displayDisabled <= gp1Data[0];
				gp1DmaDir:        dmaDir <= gp1Data[1:0];
				gp1DisplayArea, gp1RangeX, gp1RangeY: ; // Video timing lives outside this core.
				gp1DisplayMode: begin
					displayMode.horizRes    <= gp1Data[1:0];
					displayMode.vertRes     <= gp1Data[2] & gp1Data[5]; // 480 lines needs interlace.
					displayMode.videoMode   <= gp1Data[3];
					displayMode.rgb888      <= gp1Data[4];
					displayMode.interlace   <= gp1Data[5];
					displayMode.horiz368    <= gp1Data[6];
					displayMode.reverseFlag <= gp1Data[7];
				end
				default: ;                         // Resets are decoded above.
			endcase
		end
	end

	// Status word at address 1. Unlisted bits read 0.
	always_comb begin
		status = '0;
		status[stTexPageX +: 4]     = drawMode.texPageX;
		status[stTexPageY]          = drawMode.texPageY;
		status[stTransparency +: 2] = drawMode.transparency;
		status[stTexFormat +: 2]    = drawMode.texFormat;
		status[stDither]            = drawMode.dither;
		status[stDrawToDisplay]     = drawMode.drawToDisplay;
		status[stTexDisable]        = drawMode.textureDisable;
		status[stHoriz368]          = displayMode.horiz368;
		status[stHorizRes +: 2]     = displayMode.horizRes;
		status[stVertRes]           = displayMode.vertRes;
		status[stVideoMode]         = displayMode.videoMode;
		status[stRgb888]            = displayMode.rgb888;
		status[stInterlace]         = displayMode.interlace;
		status[stDispDisabled]      = displayDisabled;
		status[stCmdReady]          = cmdReady;
		status[stDmaDir +: 2]       = dmaDir;
	end

endmodule

`default_nettype wire

/* src/gp0Parser.sv */
`default_nettype none

module gp0Parser (
	input  logic                         clk,
	input  logic                         rstGPU,
	input  logic                         cmdReset,
	input  logic                         fifoEmpty,
	input  logic [gpuPkg::wordWidth-1:0] fifoData,
	input  logic                         rasterBusy,
	output logic                         fifoRead,
	output gpuPkg::drawModeT             drawMode,
	output logic signed [10:0]           offsetX,
	output logic signed [10:0]           offsetY,
	output logic                         loadVertex,
	output logic                         loadColor,
	output logic                         flatColor,
	output logic [1:0]                   slot,
	output logic                         issue,
	output logic                         semiTransp,
	output logic                         cmdReady
);
	import gpuPkg::*;

	typedef enum logic [1:0] {IDLE, LOAD_COMMAND, COLOR_LOAD, VERTEX_LOAD} stateT;

	stateT      state;
	stateT      nextLogical;
	logic       needWord;    // Next state wants a FIFO word.
	logic       dataValid;   // fifoData holds a word read last cycle.
	logic [7:0] cmdReg;
	logic [7:0] command;
	logic [1:0] vertCnt;     // Vertices stored so far, 3 means ready to issue.
	logic       isFlat;
	logic       isGouraud;
	logic       newCommand;

	assign newCommand = (state == LOAD_COMMAND) && dataValid;
	assign command    = newCommand ? fifoData[31:24] : cmdReg;
	assign isFlat     = (command[7:2] == cmdFlatTri[7:2]);
	assign isGouraud  = (command[7:2] == cmdGouraudTri[7:2]);
	assign semiTransp = cmdReg[1];
	assign slot       = vertCnt;   // Colour and vertex both target the current slot.
	assign cmdReady   = (state == IDLE);
	assign fifoRead   = needWord & ~fifoEmpty & ~rasterBusy;

	// ------------------------------------------------------------------
	// Next state and strobes.
	// ------------------------------------------------------------------
	always_comb begin
		needWord    = 1'b0;
		nextLogical = IDLE;
		loadVertex  = 1'b0;
		loadColor   = 1'b0;
		flatColor   = 1'b0;
		issue       = 1'b0;
		case (state)
			IDLE: begin
				needWord    = 1'b1;
				nextLogical = LOAD_COMMAND;
			end
			LOAD_COMMAND: if (isFlat || isGouraud) begin
				loadColor   = dataValid;           // Command word carries the first colour.
				flatColor   = isFlat;
				needWord    = 1'b1;
				nextLogical = VERTEX_LOAD;
			end                                    // Attributes and no-ops end here.
			COLOR_LOAD: begin
				loadColor   = dataValid;
				needWord    = 1'b1;
				nextLogical = VERTEX_LOAD;
			end
			VERTEX_LOAD: if (vertCnt == 2'd3) begin
				issue = 1'b1;                      // All three slots are stored.
			end else if (dataValid && vertCnt == 2'd2) begin
				loadVertex  = 1'b1;
				nextLogical = VERTEX_LOAD;         // Stay one cycle to issue.
			end else begin
				loadVertex  = dataValid;
				needWord    = 1'b1;
				nextLogical = isGouraud ? COLOR_LOAD : VERTEX_LOAD;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstGPU || cmdReset) begin
			state     <= IDLE;
			dataValid <= 1'b0;
			vertCnt   <= 2'd0;
		end else begin
			dataValid <= fifoRead;
			if (!needWord || fifoRead) state <= nextLogical; // Wait here for a word.
			if (state == IDLE)    vertCnt <= 2'd0;
			else if (loadVertex)  vertCnt <= vertCnt + 2'd1;
		end
	end

	// Attribute registers survive a command reset.
	always_ff @(posedge clk) begin
		if (rstGPU) begin
			drawMode               <= '0;
			drawMode.drawToDisplay <= 1'b1;
			offsetX                <= '0;
			offsetY                <= '0;
			cmdReg                 <= '0;
		end else if (newCommand) begin
			cmdReg <= fifoData[31:24];
			if (command == cmdDrawMode) drawMode <= fifoData[11:0];
			if (command == cmdDrawOffset) begin
				offsetX <= fifoData[10:0];
				offsetY <= fifoData[21:11];
			end
		end
	end

	// Issue follows the store of slot 2 by one cycle.
	assert property (@(posedge clk) disable iff (rstGPU || cmdReset)
		issue |-> state == VERTEX_LOAD && $past(loadVertex && slot == 2'd2))
		else $error("Issue without a third vertex.");

endmodule

`default_nettype wire

/* src/vertexStore.sv */
`default_nettype none

module vertexStore (
	input  logic                         clk,
	input  logic                         loadVertex,
	input  logic                         loadColor,
	input  logic                         flatColor,
	input  logic [1:0]                   slot,
	input  logic [gpuPkg::wordWidth-1:0] fifoData,
	input  logic signed [10:0]           offsetX,
	input  logic signed [10:0]           offsetY,
	input  logic                         issue,
	input  logic                         semiTransp,
	output gpuPkg::triangleT             triangle,
	output logic                         triIssue
);
	import gpuPkg::*;

	vertexT                       slotV [3];
	logic signed [coordWidth-1:0] xIn;
	logic signed [coordWidth-1:0] yIn;
	logic [colorWidth-1:0]        rIn;
	logic [colorWidth-1:0]        gIn;
	logic [colorWidth-1:0]        bIn;
	logic                         semiReg;

	// 0..255 to 0..256 by adding bit 7.
	function automatic logic [colorWidth-1:0] renorm(input logic [7:0] c);
		return {1'b0, c} + colorWidth'(c[7]);
	endfunction

	// Sign-extended 11-bit vertex fields plus the drawing offset.
	assign xIn = coordWidth'(signed'(fifoData[10:0])) + coordWidth'(offsetX);
	assign yIn = coordWidth'(signed'(fifoData[26:16])) + coordWidth'(offsetY);
	assign rIn = renorm(fifoData[7:0]);
	assign gIn = renorm(fifoData[15:8]);
	assign bIn = renorm(fifoData[23:16]);

	always_ff @(posedge clk) begin
		if (loadVertex) begin
			slotV[slot].x <= xIn;
			slotV[slot].y <= yIn;
		end
		for (int i = 0; i < 3; i++) begin
			if (loadColor && (flatColor || slot == i[1:0])) begin
				slotV[i].r <= rIn;   // Flat colour fills every slot.
				slotV[i].g <= gIn;
				slotV[i].b <= bIn;
			end
		end
		if (issue) semiReg <= semiTransp;
		triIssue <= issue;             // Sorter samples one cycle later.
	end

	assign triangle = '{v0: slotV[0], v1: slotV[1], v2: slotV[2], semiTransp: semiReg};

endmodule

`default_nettype wire

/* src/triangleSorter.sv */
`default_nettype none

module triangleSorter (
	input  logic             clk,
	input  logic             rstGPU,
	input  gpuPkg::triangleT triangle,
	input  logic             triIssue,
	output logic             primValid,
	output gpuPkg::triangleT prim
);
	import gpuPkg::*;

	vertexT     vtx [3];
	logic       before01;   // Vertex 0 goes ahead of vertex 1.
	logic       before02;
	logic       before12;
	logic [1:0] topId;
	logic [1:0] midId;
	logic [1:0] botId;

	assign vtx[0] = triangle.v0;
	assign vtx[1] = triangle.v1;
	assign vtx[2] = triangle.v2;

	// Ties go to the lower slot, so the order is stable.
	assign before01 = (vtx[0].y <= vtx[1].y);
	assign before02 = (vtx[0].y <= vtx[2].y);
	assign before12 = (vtx[1].y <= vtx[2].y);

	always_comb begin
		if (before01 && before02)       topId = 2'd0;
		else if (!before01 && before12) topId = 2'd1;
		else                            topId = 2'd2;
		if (before02 && before12)       botId = 2'd2;
		else if (before01 && !before12) botId = 2'd1;
		else                            botId = 2'd0;
		midId = 2'd3 - topId - botId;   // Slot ids sum to 3.
	end

	always_ff @(posedge clk) begin
		if (rstGPU) primValid <= 1'b0;
		else        primValid <= triIssue;
	end

	// Output register holds one triangle while the next one loads.
	always_ff @(posedge clk) begin
		if (triIssue) begin
			prim <= '{v0: vtx[topId], v1: vtx[midId], v2: vtx[botId],
				semiTransp: triangle.semiTransp};
		end
	end

	assert property (@(posedge clk) disable iff (rstGPU)
		primValid |-> prim.v0.y <= prim.v1.y && prim.v1.y <= prim.v2.y)
		else $error("Primitive not ordered by Y.");

endmodule

`default_nettype wire

/* src/gpu.sv */
`default_nettype none

module gpu (
	input  logic                         clk,
	input  logic                         rstGPU,
	input  logic                         cpuAddress,
	input  logic                         gpuSel,
	input  logic                         cpuWrite,
	input  logic [gpuPkg::wordWidth-1:0] cpuDataIn,
	output logic [gpuPkg::wordWidth-1:0] cpuDataOut,
	output logic                         ack,
	input  logic                         rasterBusy,
	output logic                         primValid,
	output gpuPkg::triangleT             prim
);
	import gpuPkg::*;

	logic                 writeFifo;
	logic                 gp1Write;
	logic                 resetAll;
	logic                 gpuReset;
	logic                 cmdReset;
	logic                 fifoFull;
	logic                 fifoEmpty;
	logic                 fifoRead;
	logic [wordWidth-1:0] fifoData;
	logic [wordWidth-1:0] status;
	logic                 cmdReady;
	drawModeT             drawMode;
	logic signed [10:0]   offsetX;
	logic signed [10:0]   offsetY;
	logic                 loadVertex;
	logic                 loadColor;
	logic                 flatColor;
	logic [1:0]           slot;
	logic                 issue;
	logic                 semiTransp;
	triangleT             triangle;
	logic                 triIssue;

	// ------------------------------------------------------------------
	// CPU port decode.
	// ------------------------------------------------------------------
	assign writeFifo  = gpuSel & cpuWrite & (cpuAddress == 1'b0); // GP0.
	assign gp1Write   = gpuSel & cpuWrite & (cpuAddress == 1'b1); // GP1.
	assign cpuDataOut = (gpuSel && cpuAddress == 1'b1) ? status : '0;
	assign ack        = ~fifoFull;
	assign resetAll   = rstGPU | gpuReset;   // GP1 reset acts like the pin.

	gpuCmdFifo fifo (
		.clk(clk), .rstGPU(resetAll), .flush(cmdReset),
		.wrEn(writeFifo), .wrData(cpuDataIn),
		.rdEn(fifoRead), .rdData(fifoData),
		.full(fifoFull), .empty(fifoEmpty)
	);

	gpuControlRegs ctrl (
		.clk(clk), .rstGPU(rstGPU), .gp1Write(gp1Write), .gp1Data(cpuDataIn),
		.drawMode(drawMode), .cmdReady(cmdReady),
		.gpuReset(gpuReset), .cmdReset(cmdReset), .status(status)
	);

	gp0Parser parser (
		.clk(clk), .rstGPU(resetAll), .cmdReset(cmdReset),
		.fifoEmpty(fifoEmpty), .fifoData(fifoData), .rasterBusy(rasterBusy),
		.fifoRead(fifoRead), .drawMode(drawMode),
		.offsetX(offsetX), .offsetY(offsetY),
		.loadVertex(loadVertex), .loadColor(loadColor), .flatColor(flatColor),
		.slot(slot), .issue(issue), .semiTransp(semiTransp), .cmdReady(cmdReady)
	);

	vertexStore store (
		.clk(clk), .loadVertex(loadVertex), .loadColor(loadColor),
		.flatColor(flatColor), .slot(slot), .fifoData(fifoData),
		.offsetX(offsetX), .offsetY(offsetY),
		.issue(issue), .semiTransp(semiTransp),
		.triangle(triangle), .triIssue(triIssue)
	);

	triangleSorter sorter (
		.clk(clk), .rstGPU(resetAll), .triangle(triangle), .triIssue(triIssue),
		.primValid(primValid), .prim(prim)
	);

endmodule

`default_nettype wire

/* tb/gpuModel.svh */
`ifndef gpuModelSvh
`define gpuModelSvh

// ----------------------------------------------------------------------
// Reference model, fed with every word the FIFO is expected to keep.
// ----------------------------------------------------------------------
triangleT    expQ [$];           // Triangles still to appear, in order.
vertexT      mSlot [3];          // Triangle under construction.
logic        mSemi;
logic [11:0] mDrawMode;          // Last E1 fields.
logic [10:0] mOffX;              // Last E5 offset.
logic [10:0] mOffY;
logic [7:0]  mDispMode;          // GP1 08h bits 7:0 as written.
logic        mDispDisabled;
logic [1:0]  mDmaDir;
int          wordsLeft;          // Parameter words the open triangle still needs.
int          vIdx;               // Vertices stored so far.
logic        gouraud;
logic        wantColor;

// Colour 0..255 stretched to 0..256: the top bit is added once more.
function automatic logic [8:0] renormModel(input logic [7:0] c);
	return {1'b0, c} + {8'd0, c[7]};
endfunction

// Both operands sign-extended to 13 bits.
function automatic logic [12:0] coordModel(input logic [10:0] v, input logic [10:0] off);
	return {{2{v[10]}}, v} + {{2{off[10]}}, off};
endfunction

task automatic modelReset();
	mDrawMode     = 12'h400;         // Drawing to the display area on.
	mOffX         = '0;
	mOffY         = '0;
	mDispMode     = '0;
	mDispDisabled = 1'b1;
	mDmaDir       = '0;
	wordsLeft     = 0;
endtask

task automatic setColor(input int s, input logic [31:0] w);
	mSlot[s].r = renormModel(w[7:0]);
	mSlot[s].g = renormModel(w[15:8]);
	mSlot[s].b = renormModel(w[23:16]);
endtask

// Stable sort by Y, a swap only on a strictly greater Y.
task automatic pushTriangle();
	vertexT   v [3];
	vertexT   tmp;
	triangleT t;
	v = mSlot;
	for (int pass = 0; pass < 2; pass++) begin
		for (int j = 0; j < 2; j++) begin
			if ($signed(v[j].y) > $signed(v[j+1].y)) begin
				tmp    = v[j];
				v[j]   = v[j+1];
				v[j+1] = tmp;
			end
		end
	end
	t.v0         = v[0];
	t.v1         = v[1];
	t.v2         = v[2];
	t.semiTransp = mSemi;
	expQ.push_back(t);
endtask

task automatic modelWord(input logic [31:0] w);
	if (wordsLeft == 0) begin
		if (w[31:26] == 6'b001000 || w[31:26] == 6'b001100) begin  // 0x20 or 0x30 family.
			gouraud   = w[28];
			wordsLeft = gouraud ? 5 : 3;
			vIdx      = 0;
			wantColor = 1'b0;
			mSemi     = w[25];
			for (int i = 0; i < 3; i++) begin
				if (!gouraud || i == 0) setColor(i, w);
			end
		end else if (w[31:24] == 8'hE1) begin
			mDrawMode = w[11:0];
		end else if (w[31:24] == 8'hE5) begin
			mOffX = w[10:0];
			mOffY = w[21:11];
		end                                // Anything else is a no-op.
	end else begin
		if (wantColor) begin
			setColor(vIdx, w);
			wantColor = 1'b0;
		end else begin
			mSlot[vIdx].x = coordModel(w[10:0], mOffX);
			mSlot[vIdx].y = coordModel(w[26:16], mOffY);
			vIdx++;
			wantColor = gouraud;           // Gouraud alternates vertex and colour.
		end
		wordsLeft--;
		if (wordsLeft == 0) pushTriangle();
	end
endtask

task automatic gp1Model(input logic [31:0] w);
	case (w[29:24])
		6'd0: modelReset();
		6'd1: wordsLeft = 0;               // Open triangle is thrown away.
		6'd3: mDispDisabled = w[0];
		6'd4: mDmaDir = w[1:0];
		6'd8: mDispMode = w[7:0];
		default: ;
	endcase
endtask

// Status as read while the parser sits idle.
function automatic logic [31:0] statusModel();
	logic [31:0] s;
	s        = '0;
	s[10:0]  = mDrawMode[10:0];
	s[15]    = mDrawMode[11];
	s[16]    = mDispMode[6];
	s[18:17] = mDispMode[1:0];
	s[19]    = mDispMode[2] & mDispMode[5]; // 480 lines only with interlace.
	s[20]    = mDispMode[3];
	s[21]    = mDispMode[4];
	s[22]    = mDispMode[5];
	s[23]    = mDispDisabled;
	s[26]    = 1'b1;
	s[30:29] = mDmaDir;
	return s;
endfunction

`endif

/* tb/tbGpu.sv */
`default_nettype none

module tbGpu;
	timeunit 1ns;
	timeprecision 1ps;

	import gpuPkg::*;

	localparam int nFlat         = 6;
	localparam int nGouraud      = 6;
	localparam int nGp1Rounds    = 4;
	localparam int nOverflowTris = 5;   // 20 words against a 16-word FIFO.
	localparam int totalWords    = 1 + 4 * nFlat + 7 * nGouraud + 5 * nGp1Rounds
		+ 4 * nOverflowTris + 12;
	localparam int watchdogCycles = totalWords * 40 + 1000;

	logic                 clk = 1'b0;
	logic                 rstGPU;
	logic                 cpuAddress;
	logic                 gpuSel;
	logic                 cpuWrite;
	logic [wordWidth-1:0] cpuDataIn;
	logic [wordWidth-1:0] cpuDataOut;
	logic                 ack;
	logic                 rasterBusy;
	logic                 primValid;
	triangleT             prim;

	int   seed          = 38;
	int   valueErrors   = 0;
	int   otherErrors   = 0;
	int   trianglesSeen = 0;
	int   heldWords     = 0;            // Words in the FIFO while the parser is frozen.
	logic busyPhase     = 1'b0;
	logic frozen        = 1'b0;         // No primitive may appear.

	`include "gpuModel.svh"

	gpu dut (
		.clk(clk), .rstGPU(rstGPU), .cpuAddress(cpuAddress), .gpuSel(gpuSel),
		.cpuWrite(cpuWrite), .cpuDataIn(cpuDataIn), .cpuDataOut(cpuDataOut),
		.ack(ack), .rasterBusy(rasterBusy), .primValid(primValid), .prim(prim)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------------
	// Checks and bus tasks.
	// ------------------------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		assert (gotVal === expVal) else begin
			$display("FAILED at %0d ns: %s expected %h got %h", $time, name, expVal, gotVal);
			valueErrors++;
		end
	endtask

	task automatic checkTriangle(input triangleT expTri, input triangleT gotTri);
		vertexT e [3];
		vertexT g [3];
		e = '{expTri.v0, expTri.v1, expTri.v2};
		g = '{gotTri.v0, gotTri.v1, gotTri.v2};
		for (int i = 0; i < 3; i++) begin
			checkValue($sformatf("prim.v%0d.x", i), 32'(e[i].x), 32'(g[i].x));
			checkValue($sformatf("prim.v%0d.y", i), 32'(e[i].y), 32'(g[i].y));
			checkValue($sformatf("prim.v%0d.r", i), 32'(e[i].r), 32'(g[i].r));
			checkValue($sformatf("prim.v%0d.g", i), 32'(e[i].g), 32'(g[i].g));
			checkValue($sformatf("prim.v%0d.b", i), 32'(e[i].b), 32'(g[i].b));
		end
		checkValue("prim.semiTransp", 32'(expTri.semiTransp), 32'(gotTri.semiTransp));
	endtask

	// One write cycle, sampled by the DUT at the second edge.
	task automatic writeWord(input logic addr, input logic [31:0] w);
		@(posedge clk);
		gpuSel     <= 1'b1;
		cpuAddress <= addr;
		cpuWrite   <= 1'b1;
		cpuDataIn  <= w;
		@(posedge clk);
		cpuWrite <= 1'b0;
		gpuSel   <= 1'b0;
	endtask

	task automatic sendGp0(input logic [31:0] w);
		logic accept;
		accept = !busyPhase || heldWords < fifoDepth;  // Frozen FIFO fills up.
		@(negedge clk);
		checkValue("ack", 32'(accept), 32'(ack));
		if (accept) begin
			modelWord(w);
			if (busyPhase) heldWords++;
		end
		writeWord(1'b0, w);
	endtask

	task automatic sendGp1(input logic [31:0] w);
		gp1Model(w);
		writeWord(1'b1, w);
	endtask

	// Y squeezed to 0..3 when ties are wanted.
	function automatic logic [31:0] vertexWord(input logic tieY);
		logic [31:0] r;
		r = $random(seed);
		if (tieY) r[26:18] = '0;
		return r;
	endfunction

	task automatic sendFlat(input logic tieY);
		logic [31:0] r;
		r = $random(seed);
		sendGp0({6'b001000, r[25:0]});
		repeat (3) sendGp0(vertexWord(tieY));
	endtask

	task automatic sendGouraud(input logic tieY);
		logic [31:0] r;
		r = $random(seed);
		sendGp0({6'b001100, r[25:0]});       // Colour of the first vertex.
		sendGp0(vertexWord(tieY));
		sendGp0($random(seed));
		sendGp0(vertexWord(tieY));
		sendGp0($random(seed));
		sendGp0(vertexWord(tieY));
	endtask

	// Idle means all triangles seen and cmdReady high for three cycles.
	task automatic waitIdle();
		int cycles;
		int idleRun;
		cycles  = 0;
		idleRun = 0;
		@(posedge clk);
		gpuSel     <= 1'b1;
		cpuAddress <= 1'b1;
		cpuWrite   <= 1'b0;
		while (idleRun < 3 && cycles < 2000) begin
			@(negedge clk);
			if (cpuDataOut[26] && expQ.size() == 0) idleRun++;
			else idleRun = 0;
			cycles++;
		end
		assert (idleRun >= 3) else begin
			$display("Timed out waiting for idle with %0d triangles missing", expQ.size());
			otherErrors++;
		end
	endtask

	task automatic checkStatus();
		waitIdle();
		@(negedge clk);
		checkValue("cpuDataOut", statusModel(), cpuDataOut);
		@(posedge clk);
		gpuSel <= 1'b0;
		@(negedge clk);
		checkValue("cpuDataOut", 32'd0, cpuDataOut);  // Deselected port reads zero.
	endtask

	// Every primitive is matched against the head of the model queue.
	always @(negedge clk) begin
		if (!rstGPU && primValid) begin
			assert (!frozen) else begin
				$display("Primitive issued while rasterBusy froze the parser at %0d ns", $time);
				otherErrors++;
			end
			assert (expQ.size() > 0) else begin
				$display("Primitive issued with no triangle expected at %0d ns", $time);
				otherErrors++;
			end
			if (expQ.size() > 0) begin
				checkTriangle(expQ.pop_front(), prim);
				trianglesSeen++;
			end
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles", watchdogCycles);
		$display("Errors: %0d value, %0d other", valueErrors, otherErrors + 1);
		$display("Something failed");
		$finish;
	end

	// ------------------------------------------------------------------
	// Test sequence.
	// ------------------------------------------------------------------
	initial begin
		logic [31:0] r;
		rstGPU     = 1'b1;
		cpuAddress = 1'b0;
		gpuSel     = 1'b0;
		cpuWrite   = 1'b0;
		cpuDataIn  = '0;
		rasterBusy = 1'b0;
		modelReset();
		repeat (8) @(posedge clk);
		rstGPU <= 1'b0;
		checkStatus();                        // Reset value.

		r = $random(seed);
		sendGp0({8'hE5, r[23:0]});            // Drawing offset first.
		for (int t = 0; t < nFlat; t++) sendFlat(t % 3 == 0);
		waitIdle();

		for (int t = 0; t < nGouraud; t++) begin
			r = $random(seed);
			sendGp0({8'hE1, r[23:0]});
			sendGouraud(t % 3 == 1);
			checkStatus();
		end

		for (int k = 0; k < nGp1Rounds; k++) begin
			r = $random(seed);
			sendGp1({8'h03, r[23:0]});
			r = $random(seed);
			sendGp1({8'h04, r[23:0]});
			r = $random(seed);
			r[2] = 1'b1;
			r[5] = k[0];                      // Bit 2 alone must not set 480 lines.
			sendGp1({8'h08, r[23:0]});
			r = $random(seed);
			sendGp1({8'h02, r[23:0]});        // IRQ acknowledge, nothing visible.
			r = $random(seed);
			sendGp1({8'h05, r[23:0]});        // Display area, not in status.
			checkStatus();
		end

		// Parser frozen while the FIFO overflows.
		@(posedge clk);
		rasterBusy <= 1'b1;
		busyPhase = 1'b1;
		heldWords = 0;
		frozen    = 1'b1;
		for (int t = 0; t < nOverflowTris; t++) sendFlat(1'b0);
		@(negedge clk);
		checkValue("ack", 32'd0, 32'(ack));
		repeat (10) @(posedge clk);
		rasterBusy <= 1'b0;
		frozen    = 1'b0;
		busyPhase = 1'b0;
		waitIdle();

		r = $random(seed);
		sendGp0({6'b001100, r[25:0]});        // Gouraud cut short.
		sendGp0(vertexWord(1'b0));
		sendGp1(32'h0100_0000);               // Command reset.
		sendFlat(1'b1);
		checkStatus();
		sendGp1(32'h0000_0000);               // Full GPU reset.
		checkStatus();
		sendFlat(1'b0);                       // Offset back at zero.
		waitIdle();

		$display("Errors: %0d value, %0d other, %0d triangles checked",
			valueErrors, otherErrors, trianglesSeen);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+tb
src/gpuPkg.sv
src/gpuCmdFifo.sv
src/gpuControlRegs.sv
src/gp0Parser.sv
src/vertexStore.sv
src/triangleSorter.sv
src/gpu.sv
tb/tbGpu.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the failure line.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tbGpu -f tb.f -o simGpu \
	&& ./obj_dir/simGpu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log \
	&& { echo "Result: FAIL"; exit 1; } \
	|| { echo "Result: PASS"; exit 0; }
